// File: verilog/seq_instr_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RISC-V instruction encodings seen by the FPU sequencer: field positions,
// opcodes, frep layout and the int/float synchronising funct5 codes.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package seq_instr_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [31:0] data_t;
  typedef logic [31:0] addr_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [4:0]  qid_t;
  typedef logic [1:0]  acc_addr_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [4:0]  funct5_t;
  typedef logic [2:0]  funct3_t;

  // register fields
  localparam int unsigned RegIdxBits = 5;
  localparam int unsigned RdLsb      = 7;
  localparam int unsigned Rs1Lsb     = 15;
  localparam int unsigned Rs2Lsb     = 20;
  localparam int unsigned Rs3Lsb     = 27;
  localparam int unsigned Funct3Lsb  = 12;
  localparam int unsigned Funct5Lsb  = 27;

  // frep layout
  localparam int unsigned FrepIsOuterBit = 7;
  localparam int unsigned FrepStgMaskLsb = 8;
  localparam int unsigned FrepStgMaxLsb  = 12;
  localparam int unsigned FrepMaxInstLsb = 20;

  localparam opcode_t OpcodeFrep   = 7'b0001011;  // custom-0
  localparam opcode_t OpcodeOpFp   = 7'b1010011;
  localparam opcode_t OpcodeSystem = 7'b1110011;

  // OP-FP funct5 values that move data between the int and float side
  localparam funct5_t F5Cmp        = 5'b10100;  // feq, flt, fle
  localparam funct5_t F5MvXClass   = 5'b11100;  // fmv.x.w and fclass
  localparam funct5_t F5CvtToInt   = 5'b11000;
  localparam funct5_t F5CvtFromInt = 5'b11010;
  localparam funct5_t F5MvFromInt  = 5'b11110;

endpackage

`default_nettype wire

// File: verilog/seq_cfg_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sequencer geometry: ring buffer and config FIFO sizes, pointer and
// counter types, and the accelerator address used for replayed issues.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package seq_cfg_pkg;

  // body ring buffer
  localparam int unsigned Depth     = 8;
  localparam int unsigned DepthBits = 3;
  localparam int unsigned RptBits   = 16;

  // ring pointer, msb is the wrap bit
  typedef logic [DepthBits:0]   ptr_t;
  typedef logic [DepthBits-1:0] idx_t;
  typedef logic [RptBits-1:0]   rpt_t;
  typedef logic [2:0]           stg_t;
  // one bit each for rd, rs1, rs2, rs3
  typedef logic [3:0]           stg_mask_t;

  // frep config FIFO
  localparam int unsigned CfgDepth   = 4;
  localparam int unsigned CfgPtrBits = 2;

  typedef logic [CfgPtrBits:0]   cfg_ptr_t;
  typedef logic [CfgPtrBits-1:0] cfg_idx_t;

  // replayed issues always target the FP subsystem
  localparam seq_instr_pkg::acc_addr_t DstAddr = 2'd1;

endpackage

`default_nettype wire

// File: verilog/seq_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Internal buses of the sequencer: the active frep config and the ring
// buffer read side shared by buffer, controller and composer.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

interface seq_cfg_if;
  import seq_cfg_pkg::*;

  logic      cfg_valid;
  logic      is_outer;
  idx_t      max_inst;
  rpt_t      max_rpt;
  stg_t      stg_max;
  stg_mask_t stg_mask;
  ptr_t      base_ptr;
  logic      pop;

  modport fifo (output cfg_valid, is_outer, max_inst, max_rpt, stg_max, stg_mask,
                input  base_ptr, pop);
  modport ctrl (input  cfg_valid, is_outer, max_inst, max_rpt, stg_max,
                output base_ptr, pop);
  modport comp (input  stg_mask);
endinterface

interface seq_rd_if;
  import seq_instr_pkg::*;
  import seq_cfg_pkg::*;

  ptr_t   rd_ptr;
  ptr_t   base_ptr;
  instr_t rd_instr;
  addr_t  rd_argc;
  logic   empty;
  logic   has_instr;
  logic   advance;
  ptr_t   adv_count;
  logic   next;

  modport buffer (input  rd_ptr, base_ptr, advance, adv_count,
                  output rd_instr, rd_argc, empty, has_instr);
  modport ctrl   (output rd_ptr, base_ptr, advance, adv_count, input next);
  modport comp   (input  rd_instr, rd_argc, empty, has_instr, output next);
endinterface

`default_nettype wire

// File: verilog/instr_classifier.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Sorts each offloaded instruction onto the config, buffer or direct route
// and returns the ready of the chosen route.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module instr_classifier (
  input  seq_instr_pkg::instr_t inp_qdata_op_i,
  input  logic                  inp_qvalid_i,
  output logic                  inp_qready_o,
  output logic                  cfg_valid_o,
  input  logic                  cfg_ready_i,
  output logic                  rb_valid_o,
  input  logic                  rb_ready_i,
  output logic                  dir_valid_o,
  input  logic                  dir_ready_i
);
  import seq_instr_pkg::*;

  opcode_t opcode;
  funct5_t funct5;
  funct3_t funct3;
  logic    is_frep;
  logic    is_sync;

  assign opcode = inp_qdata_op_i[6:0];
  assign funct5 = inp_qdata_op_i[Funct5Lsb +: 5];
  assign funct3 = inp_qdata_op_i[Funct3Lsb +: 3];

  assign is_frep = (opcode == OpcodeFrep);

  // compares, classify, moves and converts across the int/float boundary,
  // plus every csr access
  always_comb begin
    is_sync = 1'b0;
    if (opcode == OpcodeOpFp) begin
      is_sync = funct5 inside {F5Cmp, F5MvXClass, F5CvtToInt, F5CvtFromInt, F5MvFromInt};
    end else if (opcode == OpcodeSystem) begin
      is_sync = (funct3 != 3'b000);
    end
  end

  assign cfg_valid_o = inp_qvalid_i && is_frep;
  assign dir_valid_o = inp_qvalid_i && !is_frep && is_sync;
  assign rb_valid_o  = inp_qvalid_i && !is_frep && !is_sync;

  assign inp_qready_o = is_frep ? cfg_ready_i :
                        is_sync ? dir_ready_i : rb_ready_i;

endmodule

`default_nettype wire

// File: verilog/seq_cfg_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Queue of decoded frep configs. Each entry carries the buffer write
// pointer at push time and only becomes active once the base reaches it.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module seq_cfg_fifo (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  push_i,
  input  seq_instr_pkg::instr_t op_i,
  input  seq_cfg_pkg::rpt_t     max_rpt_i,
  input  seq_cfg_pkg::ptr_t     wr_ptr_i,
  output logic                  full_o,
  seq_cfg_if.fifo               cfg
);
  import seq_instr_pkg::*;
  import seq_cfg_pkg::*;

  logic      is_outer_q [CfgDepth];
  idx_t      max_inst_q [CfgDepth];
  rpt_t      max_rpt_q  [CfgDepth];
  stg_t      stg_max_q  [CfgDepth];
  stg_mask_t stg_mask_q [CfgDepth];
  ptr_t      tag_q      [CfgDepth];

  cfg_ptr_t wr_q, rd_q;
  cfg_idx_t wr_idx, rd_idx;
  logic     empty, push;

  assign wr_idx = wr_q[CfgPtrBits-1:0];
  assign rd_idx = rd_q[CfgPtrBits-1:0];
  assign empty  = (wr_q == rd_q);
  assign full_o = ((wr_q ^ rd_q) == cfg_ptr_t'(CfgDepth));
  assign push   = push_i && !full_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_q <= '0;
      rd_q <= '0;
    end else begin
      if (push) wr_q <= wr_q + cfg_ptr_t'(1);
      if (cfg.pop) rd_q <= rd_q + cfg_ptr_t'(1);
    end
  end

  // decode frep fields on the way in
  always_ff @(posedge clk_i) begin
    if (push) begin
      is_outer_q[wr_idx] <= op_i[FrepIsOuterBit];
      max_inst_q[wr_idx] <= op_i[FrepMaxInstLsb +: DepthBits];
      stg_max_q[wr_idx]  <= op_i[FrepStgMaxLsb +: 3];
      stg_mask_q[wr_idx] <= op_i[FrepStgMaskLsb +: 4];
      max_rpt_q[wr_idx]  <= max_rpt_i;
      tag_q[wr_idx]      <= wr_ptr_i;
    end
  end

  // head applies only once the body it belongs to is at the base
  assign cfg.cfg_valid = !empty && (tag_q[rd_idx] == cfg.base_ptr);

  // inactive config reads as a single plain issue
  assign cfg.is_outer = cfg.cfg_valid && is_outer_q[rd_idx];
  assign cfg.max_inst = cfg.cfg_valid ? max_inst_q[rd_idx] : '0;
  assign cfg.max_rpt  = cfg.cfg_valid ? max_rpt_q[rd_idx]  : '0;
  assign cfg.stg_max  = cfg.cfg_valid ? stg_max_q[rd_idx]  : '0;
  assign cfg.stg_mask = cfg.cfg_valid ? stg_mask_q[rd_idx] : '0;

endmodule

`default_nettype wire

// File: verilog/seq_ringbuffer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Body storage for replayed instructions. The controller owns the base and
// read pointers, this block owns the write pointer and the status flags.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module seq_ringbuffer (
  input  logic                  clk_i,
  input  logic                  arst_n_i,
  input  logic                  wr_en_i,
  input  seq_instr_pkg::instr_t wr_instr_i,
  input  seq_instr_pkg::addr_t  wr_argc_i,
  output logic                  full_o,
  output seq_cfg_pkg::ptr_t     wr_ptr_o,
  seq_rd_if.buffer              rd
);
  import seq_instr_pkg::*;
  import seq_cfg_pkg::*;

  instr_t mem_op   [Depth];
  addr_t  mem_argc [Depth];

  ptr_t wr_q;
  ptr_t base_nxt;
  logic wr;

  // slots of a finishing body are free again in the same cycle
  assign base_nxt = rd.advance ? rd.base_ptr + rd.adv_count : rd.base_ptr;

  // measured from the base so a body under replay is never overwritten
  assign full_o = ((wr_q ^ base_nxt) == ptr_t'(Depth));
  assign wr     = wr_en_i && !full_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_q <= '0;
    end else if (wr) begin
      wr_q <= wr_q + ptr_t'(1);
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr) begin
      mem_op[wr_q[DepthBits-1:0]]   <= wr_instr_i;
      mem_argc[wr_q[DepthBits-1:0]] <= wr_argc_i;
    end
  end

  assign rd.rd_instr  = mem_op[rd.rd_ptr[DepthBits-1:0]];
  assign rd.rd_argc   = mem_argc[rd.rd_ptr[DepthBits-1:0]];
  assign rd.empty     = (rd.rd_ptr == wr_q);
  assign rd.has_instr = (rd.base_ptr != wr_q);
  assign wr_ptr_o     = wr_q;

endmodule

`default_nettype wire

// File: verilog/seq_controller.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Replay control. Steps instruction, repeat and stagger counters on every
// handed-over issue and moves the base past a body once it is finished.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module seq_controller (
  input  logic              clk_i,
  input  logic              arst_n_i,
  seq_cfg_if.ctrl           cfg,
  seq_rd_if.ctrl            rd,
  output seq_cfg_pkg::stg_t stg_cnt_o,
  output logic              repd_o
);
  import seq_cfg_pkg::*;

  idx_t inst_q, inst_d;
  rpt_t rpt_q, rpt_d;
  stg_t stg_q, stg_d;
  stg_t stg_inc;
  ptr_t base_q, base_d;
  logic inst_last, rpt_last, seq_last;

  assign inst_last = (inst_q == cfg.max_inst);
  assign rpt_last  = (rpt_q == cfg.max_rpt);
  assign seq_last  = inst_last && rpt_last;

  // stagger wraps after stg_max
  assign stg_inc = (stg_q == cfg.stg_max) ? '0 : stg_q + stg_t'(1);

  assign rd.base_ptr  = base_q;
  assign cfg.base_ptr = base_q;
  assign rd.rd_ptr    = base_q + ptr_t'(inst_q);
  assign rd.adv_count = ptr_t'(cfg.max_inst) + ptr_t'(1);
  assign rd.advance   = seq_last && rd.next;
  assign cfg.pop      = rd.advance && cfg.cfg_valid;

  assign base_d = rd.advance ? base_q + rd.adv_count : base_q;

  always_comb begin
    inst_d = inst_q;
    rpt_d  = rpt_q;
    stg_d  = stg_q;
    if (rd.next) begin
      if (cfg.is_outer) begin
        // whole body per repeat
        if (inst_last) begin
          inst_d = '0;
          rpt_d  = rpt_last ? '0 : rpt_q + rpt_t'(1);
          stg_d  = rpt_last ? '0 : stg_inc;
        end else begin
          inst_d = inst_q + idx_t'(1);
        end
      end else begin
        // each instruction repeated back to back
        if (rpt_last) begin
          rpt_d  = '0;
          inst_d = inst_last ? '0 : inst_q + idx_t'(1);
          stg_d  = '0;
        end else begin
          rpt_d = rpt_q + rpt_t'(1);
          stg_d = stg_inc;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      inst_q <= '0;
      rpt_q  <= '0;
      stg_q  <= '0;
      base_q <= '0;
    end else begin
      inst_q <= inst_d;
      rpt_q  <= rpt_d;
      stg_q  <= stg_d;
      base_q <= base_d;
    end
  end

  assign stg_cnt_o = stg_q;
  assign repd_o    = (rpt_q != '0);

endmodule

`default_nettype wire

// File: verilog/issue_composer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Output stage. Staggers register fields of replayed instructions and
// gives the ring buffer priority over the direct path.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module issue_composer (
  seq_cfg_if.comp                  cfg,
  seq_rd_if.comp                   rd,
  input  seq_cfg_pkg::stg_t        stg_cnt_i,
  input  logic                     repd_i,
  input  seq_instr_pkg::acc_addr_t inp_qaddr_i,
  input  seq_instr_pkg::qid_t      inp_qid_i,
  input  seq_instr_pkg::instr_t    inp_qdata_op_i,
  input  seq_instr_pkg::data_t     inp_qdata_arga_i,
  input  seq_instr_pkg::data_t     inp_qdata_argb_i,
  input  seq_instr_pkg::addr_t     inp_qdata_argc_i,
  input  logic                     dir_valid_i,
  output logic                     dir_ready_o,
  output seq_instr_pkg::acc_addr_t oup_qaddr_o,
  output seq_instr_pkg::qid_t      oup_qid_o,
  output seq_instr_pkg::instr_t    oup_qdata_op_o,
  output seq_instr_pkg::data_t     oup_qdata_arga_o,
  output seq_instr_pkg::data_t     oup_qdata_argb_o,
  output seq_instr_pkg::addr_t     oup_qdata_argc_o,
  output logic                     oup_qdata_repd_o,
  output logic                     oup_qvalid_o,
  input  logic                     oup_qready_i
);
  import seq_instr_pkg::*;
  import seq_cfg_pkg::*;

  instr_t   seq_op;
  reg_idx_t stg_ext;

  assign stg_ext = reg_idx_t'(stg_cnt_i);

  // register indices wrap modulo 32
  always_comb begin
    seq_op = rd.rd_instr;
    if (cfg.stg_mask[0]) seq_op[RdLsb +: RegIdxBits] = seq_op[RdLsb +: RegIdxBits] + stg_ext;
    if (cfg.stg_mask[1]) seq_op[Rs1Lsb +: RegIdxBits] = seq_op[Rs1Lsb +: RegIdxBits] + stg_ext;
    if (cfg.stg_mask[2]) seq_op[Rs2Lsb +: RegIdxBits] = seq_op[Rs2Lsb +: RegIdxBits] + stg_ext;
    if (cfg.stg_mask[3]) seq_op[Rs3Lsb +: RegIdxBits] = seq_op[Rs3Lsb +: RegIdxBits] + stg_ext;
  end

  always_comb begin
    oup_qvalid_o     = dir_valid_i;
    oup_qaddr_o      = inp_qaddr_i;
    oup_qid_o        = inp_qid_i;
    oup_qdata_op_o   = inp_qdata_op_i;
    oup_qdata_arga_o = inp_qdata_arga_i;
    oup_qdata_argb_o = inp_qdata_argb_i;
    oup_qdata_argc_o = inp_qdata_argc_i;
    oup_qdata_repd_o = 1'b0;
    dir_ready_o      = oup_qready_i;
    rd.next          = 1'b0;
    // direct requests wait until the buffer has drained
    if (rd.has_instr) begin
      oup_qvalid_o     = !rd.empty;
      oup_qaddr_o      = DstAddr;
      oup_qid_o        = '0;
      oup_qdata_op_o   = seq_op;
      oup_qdata_arga_o = '0;
      oup_qdata_argb_o = '0;
      oup_qdata_argc_o = rd.rd_argc;
      oup_qdata_repd_o = repd_i;
      dir_ready_o      = 1'b0;
      rd.next          = !rd.empty && oup_qready_i;
    end
  end

endmodule

`default_nettype wire

// File: verilog/fpu_sequencer.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// FPU instruction sequencer top. Sits between the core offload port and
// the FP subsystem and replays frep loop bodies.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fpu_sequencer (
  input  logic                     clk_i,
  input  logic                     arst_n_i,
  input  seq_instr_pkg::acc_addr_t inp_qaddr_i,
  input  seq_instr_pkg::qid_t      inp_qid_i,
  input  seq_instr_pkg::instr_t    inp_qdata_op_i,
  input  seq_instr_pkg::data_t     inp_qdata_arga_i,
  input  seq_instr_pkg::data_t     inp_qdata_argb_i,
  input  seq_instr_pkg::addr_t     inp_qdata_argc_i,
  input  logic                     inp_qvalid_i,
  output logic                     inp_qready_o,
  output seq_instr_pkg::acc_addr_t oup_qaddr_o,
  output seq_instr_pkg::qid_t      oup_qid_o,
  output seq_instr_pkg::instr_t    oup_qdata_op_o,
  output seq_instr_pkg::data_t     oup_qdata_arga_o,
  output seq_instr_pkg::data_t     oup_qdata_argb_o,
  output seq_instr_pkg::addr_t     oup_qdata_argc_o,
  output logic                     oup_qdata_repd_o,
  output logic                     oup_qvalid_o,
  input  logic                     oup_qready_i
);
  import seq_cfg_pkg::*;

  logic cfg_valid, cfg_full;
  logic rb_valid, rb_full;
  logic dir_valid, dir_ready;
  ptr_t wr_ptr;
  stg_t stg_cnt;
  logic repd;

  seq_cfg_if cfg_if ();
  seq_rd_if  rd_if ();

  instr_classifier i_classifier (
    .inp_qdata_op_i (inp_qdata_op_i),
    .inp_qvalid_i   (inp_qvalid_i),
    .inp_qready_o   (inp_qready_o),
    .cfg_valid_o    (cfg_valid),
    .cfg_ready_i    (!cfg_full),
    .rb_valid_o     (rb_valid),
    .rb_ready_i     (!rb_full),
    .dir_valid_o    (dir_valid),
    .dir_ready_i    (dir_ready)
  );

  // repeat count comes in on operand a
  seq_cfg_fifo i_cfg_fifo (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .push_i    (cfg_valid),
    .op_i      (inp_qdata_op_i),
    .max_rpt_i (inp_qdata_arga_i[RptBits-1:0]),
    .wr_ptr_i  (wr_ptr),
    .full_o    (cfg_full),
    .cfg       (cfg_if.fifo)
  );

  seq_ringbuffer i_ringbuffer (
    .clk_i      (clk_i),
    .arst_n_i   (arst_n_i),
    .wr_en_i    (rb_valid),
    .wr_instr_i (inp_qdata_op_i),
    .wr_argc_i  (inp_qdata_argc_i),
    .full_o     (rb_full),
    .wr_ptr_o   (wr_ptr),
    .rd         (rd_if.buffer)
  );

  seq_controller i_controller (
    .clk_i     (clk_i),
    .arst_n_i  (arst_n_i),
    .cfg       (cfg_if.ctrl),
    .rd        (rd_if.ctrl),
    .stg_cnt_o (stg_cnt),
    .repd_o    (repd)
  );

  issue_composer i_composer (
    .cfg              (cfg_if.comp),
    .rd               (rd_if.comp),
    .stg_cnt_i        (stg_cnt),
    .repd_i           (repd),
    .inp_qaddr_i      (inp_qaddr_i),
    .inp_qid_i        (inp_qid_i),
    .inp_qdata_op_i   (inp_qdata_op_i),
    .inp_qdata_arga_i (inp_qdata_arga_i),
    .inp_qdata_argb_i (inp_qdata_argb_i),
    .inp_qdata_argc_i (inp_qdata_argc_i),
    .dir_valid_i      (dir_valid),
    .dir_ready_o      (dir_ready),
    .oup_qaddr_o      (oup_qaddr_o),
    .oup_qid_o        (oup_qid_o),
    .oup_qdata_op_o   (oup_qdata_op_o),
    .oup_qdata_arga_o (oup_qdata_arga_o),
    .oup_qdata_argb_o (oup_qdata_argb_o),
    .oup_qdata_argc_o (oup_qdata_argc_o),
    .oup_qdata_repd_o (oup_qdata_repd_o),
    .oup_qvalid_o     (oup_qvalid_o),
    .oup_qready_i     (oup_qready_i)
  );

endmodule

`default_nettype wire

// File: sim/fpu_sequencer_tb.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Table-driven testbench for the FPU sequencer. A reference model expands
// each case into the expected issue stream under random back-pressure.
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module fpu_sequencer_tb;
  import seq_instr_pkg::*;
  import seq_cfg_pkg::*;

  localparam int MaxRows  = 32;
  localparam int KindBuf  = 0;
  localparam int KindFrep = 1;
  localparam int KindSync = 2;

  typedef struct packed {
    acc_addr_t addr;
    qid_t      id;
    instr_t    op;
    data_t     arga;
    data_t     argb;
    addr_t     argc;
    logic      repd;
  } issue_t;

  logic      clk_i;
  logic      arst_n_i;
  acc_addr_t inp_qaddr_i;
  qid_t      inp_qid_i;
  instr_t    inp_qdata_op_i;
  data_t     inp_qdata_arga_i;
  data_t     inp_qdata_argb_i;
  addr_t     inp_qdata_argc_i;
  logic      inp_qvalid_i;
  logic      inp_qready_o;
  acc_addr_t oup_qaddr_o;
  qid_t      oup_qid_o;
  instr_t    oup_qdata_op_o;
  data_t     oup_qdata_arga_o;
  data_t     oup_qdata_argb_o;
  addr_t     oup_qdata_argc_o;
  logic      oup_qdata_repd_o;
  logic      oup_qvalid_o;
  logic      oup_qready_i;

  // stimulus table, one row per offered instruction
  int     row_case [MaxRows];
  int     row_kind [MaxRows];
  instr_t row_op   [MaxRows];
  data_t  row_arga [MaxRows];
  addr_t  row_argc [MaxRows];
  int     num_rows;
  int     num_cases;
  int     max_rpt;
  issue_t expect_q [$];
  integer seed;
  int     cycle_cnt;
  int     cycle_limit;

  fpu_sequencer fpu_sequencer_inst (
    .clk_i            (clk_i),
    .arst_n_i         (arst_n_i),
    .inp_qaddr_i      (inp_qaddr_i),
    .inp_qid_i        (inp_qid_i),
    .inp_qdata_op_i   (inp_qdata_op_i),
    .inp_qdata_arga_i (inp_qdata_arga_i),
    .inp_qdata_argb_i (inp_qdata_argb_i),
    .inp_qdata_argc_i (inp_qdata_argc_i),
    .inp_qvalid_i     (inp_qvalid_i),
    .inp_qready_o     (inp_qready_o),
    .oup_qaddr_o      (oup_qaddr_o),
    .oup_qid_o        (oup_qid_o),
    .oup_qdata_op_o   (oup_qdata_op_o),
    .oup_qdata_arga_o (oup_qdata_arga_o),
    .oup_qdata_argb_o (oup_qdata_argb_o),
    .oup_qdata_argc_o (oup_qdata_argc_o),
    .oup_qdata_repd_o (oup_qdata_repd_o),
    .oup_qvalid_o     (oup_qvalid_o),
    .oup_qready_i     (oup_qready_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Done: errors found");
    $fatal(1, "simulation stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] want);
    if (got !== want) begin
      report_failure($sformatf("FAILED at %0t ns: %s got %h expected %h",
                               $time, name, got, want));
    end
  endtask

  function automatic instr_t rtype(input logic [4:0] f5, input logic [4:0] rs2,
                                   input logic [4:0] rs1, input logic [2:0] f3,
                                   input logic [4:0] rd, input logic [6:0] opc);
    return {f5, 2'b00, rs2, rs1, f3, rd, opc};
  endfunction

  // register fields rd, rs1, rs2, rs3 each wrap modulo 32
  function automatic instr_t staggered(input instr_t op, input logic [3:0] mask,
                                       input int stg);
    instr_t     res;
    logic [4:0] s;
    res = op;
    s = stg[4:0];
    if (mask[0]) res[11:7] = op[11:7] + s;
    if (mask[1]) res[19:15] = op[19:15] + s;
    if (mask[2]) res[24:20] = op[24:20] + s;
    if (mask[3]) res[31:27] = op[31:27] + s;
    return res;
  endfunction

  function automatic issue_t seq_issue(input instr_t op, input addr_t argc,
                                       input logic repd);
    issue_t it;
    it.addr = DstAddr;
    it.id   = '0;
    it.op   = op;
    it.arga = '0;
    it.argb = '0;
    it.argc = argc;
    it.repd = repd;
    return it;
  endfunction

  task automatic add_row(input int kind, input instr_t op, input int rpt);
    row_case[num_rows] = num_cases;
    row_kind[num_rows] = kind;
    row_op[num_rows]   = op;
    row_arga[num_rows] = (kind == KindFrep) ? data_t'(rpt) : 32'haa00_0000 + num_rows;
    row_argc[num_rows] = 32'hc000_0000 + 32'(num_rows * 16);
    if (kind == KindFrep && rpt > max_rpt) max_rpt = rpt;
    num_rows++;
  endtask

  task automatic add_frep(input bit outer, input int n, input int s,
                          input logic [3:0] mask, input int rpt);
    if (n >= Depth) report_failure("ERROR: frep body does not fit the ring buffer");
    add_row(KindFrep, {9'd0, n[2:0], 5'd0, s[2:0], mask, outer, 7'b0001011}, rpt);
  endtask

  task automatic build_table();
    // plain instructions only
    add_row(KindBuf, rtype(5'b00000, 5'd2, 5'd1, 3'b000, 5'd3, 7'b1010011), 0);
    add_row(KindBuf, rtype(5'b00001, 5'd4, 5'd3, 3'b000, 5'd5, 7'b1010011), 0);
    add_row(KindBuf, rtype(5'b00010, 5'd6, 5'd5, 3'b000, 5'd7, 7'b1010011), 0);
    num_cases++;
    // outer loop, three-instruction body
    add_frep(1'b1, 2, 0, 4'b0000, 2);
    add_row(KindBuf, rtype(5'b00000, 5'd9, 5'd8, 3'b000, 5'd10, 7'b1010011), 0);
    add_row(KindBuf, rtype(5'b00011, 5'd10, 5'd8, 3'b000, 5'd11, 7'b1010011), 0);
    add_row(KindBuf, rtype(5'b00001, 5'd11, 5'd9, 3'b000, 5'd12, 7'b1010011), 0);
    num_cases++;
    // inner loop
    add_frep(1'b0, 1, 0, 4'b0000, 2);
    add_row(KindBuf, rtype(5'b00000, 5'd14, 5'd13, 3'b000, 5'd15, 7'b1010011), 0);
    add_row(KindBuf, rtype(5'b00010, 5'd16, 5'd15, 3'b000, 5'd17, 7'b1010011), 0);
    num_cases++;
    // outer stagger on rd and rs1, rd wraps past 31
    add_frep(1'b1, 1, 1, 4'b0011, 3);
    add_row(KindBuf, rtype(5'b00000, 5'd2, 5'd30, 3'b000, 5'd31, 7'b1010011), 0);
    add_row(KindBuf, rtype(5'b00011, 5'd4, 5'd6, 3'b000, 5'd8, 7'b1010011), 0);
    num_cases++;
    // inner stagger on rs2 and rs3 of an fmadd
    add_frep(1'b0, 1, 2, 4'b1100, 3);
    add_row(KindBuf, rtype(5'd29, 5'd31, 5'd1, 3'b000, 5'd30, 7'b1000011), 0);
    add_row(KindBuf, rtype(5'b00000, 5'd20, 5'd21, 3'b000, 5'd22, 7'b1010011), 0);
    num_cases++;
    // fmv.x.w, feq.s, csrrw straight through
    add_row(KindSync, rtype(5'b11100, 5'd0, 5'd4, 3'b000, 5'd9, 7'b1010011), 0);
    add_row(KindSync, rtype(5'b10100, 5'd5, 5'd4, 3'b010, 5'd10, 7'b1010011), 0);
    add_row(KindSync, rtype(5'b00000, 5'd1, 5'd7, 3'b001, 5'd11, 7'b1110011), 0);
    num_cases++;
    // sync offered while the body still replays
    add_frep(1'b1, 1, 0, 4'b0000, 2);
    add_row(KindBuf, rtype(5'b00000, 5'd1, 5'd2, 3'b000, 5'd3, 7'b1010011), 0);
    add_row(KindBuf, rtype(5'b00001, 5'd3, 5'd2, 3'b000, 5'd4, 7'b1010011), 0);
    add_row(KindSync, rtype(5'b10100, 5'd4, 5'd3, 3'b010, 5'd6, 7'b1010011), 0);
    num_cases++;
    // plain ahead of an frep, then a csr access
    add_row(KindBuf, rtype(5'b00000, 5'd8, 5'd7, 3'b000, 5'd6, 7'b1010011), 0);
    add_frep(1'b1, 0, 3, 4'b0001, 1);
    add_row(KindBuf, rtype(5'b00011, 5'd12, 5'd11, 3'b000, 5'd13, 7'b1010011), 0);
    add_row(KindSync, rtype(5'b00000, 5'd2, 5'd0, 3'b001, 5'd14, 7'b1110011), 0);
    num_cases++;
  endtask

  // reference model: expand one case into its expected issue stream
  task automatic build_expected(input int c);
    issue_t     it;
    instr_t     body [$];
    addr_t      body_argc [$];
    int         need;
    int         outer;
    int         rpt;
    int         smax;
    logic [3:0] mask;
    need = 0;
    for (int r = 0; r < num_rows; r++) begin
      if (row_case[r] != c) continue;
      if (row_kind[r] == KindFrep) begin
        outer = row_op[r][7];
        mask  = row_op[r][11:8];
        smax  = row_op[r][14:12];
        need  = row_op[r][22:20] + 1;
        rpt   = row_arga[r];
        body.delete();
        body_argc.delete();
      end else if (row_kind[r] == KindSync) begin
        it.addr = 2'd2;
        it.id   = qid_t'(r + 3);
        it.op   = row_op[r];
        it.arga = row_arga[r];
        it.argb = 32'hbb00_0000 + r;
        it.argc = row_argc[r];
        it.repd = 1'b0;
        expect_q.push_back(it);
      end else if (need == 0) begin
        expect_q.push_back(seq_issue(row_op[r], row_argc[r], 1'b0));
      end else begin
        body.push_back(row_op[r]);
        body_argc.push_back(row_argc[r]);
        if (body.size() == need) begin
          // stagger steps per pass in outer mode, per repeat in inner mode
          if (outer != 0) begin
            for (int p = 0; p <= rpt; p++) begin
              for (int i = 0; i < need; i++) begin
                expect_q.push_back(seq_issue(staggered(body[i], mask, p % (smax + 1)),
                                             body_argc[i], p != 0));
              end
            end
          end else begin
            for (int i = 0; i < need; i++) begin
              for (int p = 0; p <= rpt; p++) begin
                expect_q.push_back(seq_issue(staggered(body[i], mask, p % (smax + 1)),
                                             body_argc[i], p != 0));
              end
            end
          end
          need = 0;
        end
      end
    end
  endtask

  // called on a rising edge, returns on the edge of the last handshake
  task automatic drive_case(input int c);
    for (int r = 0; r < num_rows; r++) begin
      if (row_case[r] == c) begin
        inp_qvalid_i     <= 1'b1;
        inp_qaddr_i      <= 2'd2;
        inp_qid_i        <= qid_t'(r + 3);
        inp_qdata_op_i   <= row_op[r];
        inp_qdata_arga_i <= row_arga[r];
        inp_qdata_argb_i <= 32'hbb00_0000 + r;
        inp_qdata_argc_i <= row_argc[r];
        do @(negedge clk_i); while (!inp_qready_o);
        @(posedge clk_i);
      end
    end
    inp_qvalid_i <= 1'b0;
  endtask

  always @(posedge clk_i) begin
    oup_qready_i <= (($random(seed) & 3) != 0);
  end

  always @(negedge clk_i) begin : issue_monitor
    issue_t want;
    if (arst_n_i && oup_qvalid_o && oup_qready_i) begin
      if (expect_q.size() == 0) begin
        report_failure("ERROR: the DUT issued an instruction that was not expected");
      end else begin
        want = expect_q.pop_front();
        check_value("oup_qaddr_o", 32'(oup_qaddr_o), 32'(want.addr));
        check_value("oup_qid_o", 32'(oup_qid_o), 32'(want.id));
        check_value("oup_qdata_op_o", oup_qdata_op_o, want.op);
        check_value("oup_qdata_arga_o", oup_qdata_arga_o, want.arga);
        check_value("oup_qdata_argb_o", oup_qdata_argb_o, want.argb);
        check_value("oup_qdata_argc_o", oup_qdata_argc_o, want.argc);
        check_value("oup_qdata_repd_o", 32'(oup_qdata_repd_o), 32'(want.repd));
      end
    end
  end

  always @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cycle_cnt <= 0;
    end else begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
        report_failure($sformatf("ERROR: timeout after %0d cycles, the output stalled",
                                 cycle_cnt));
      end
    end
  end

  initial begin
    arst_n_i         = 1'b0;
    inp_qaddr_i      = '0;
    inp_qid_i        = '0;
    inp_qdata_op_i   = '0;
    inp_qdata_arga_i = '0;
    inp_qdata_argb_i = '0;
    inp_qdata_argc_i = '0;
    inp_qvalid_i     = 1'b0;
    oup_qready_i     = 1'b0;
    seed             = 76125;
    num_rows         = 0;
    num_cases        = 0;
    max_rpt          = 0;
    build_table();
    cycle_limit = 64 * num_rows * (max_rpt + 1);
    repeat (3) @(posedge clk_i);
    arst_n_i <= 1'b1;
    for (int c = 0; c < num_cases; c++) begin
      build_expected(c);
      @(posedge clk_i);
      drive_case(c);
      while (expect_q.size() != 0) @(posedge clk_i);
    end
    // idle tail, any further issue is a duplicate
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    check_value("oup_qvalid_o", 32'(oup_qvalid_o), 32'd0);
    $display("Done: no errors");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
verilog/seq_instr_pkg.sv
verilog/seq_cfg_pkg.sv
verilog/seq_if.sv
verilog/instr_classifier.sv
verilog/seq_cfg_fifo.sv
verilog/seq_ringbuffer.sv
verilog/seq_controller.sv
verilog/issue_composer.sv
verilog/fpu_sequencer.sv
sim/fpu_sequencer_tb.sv
